// ==== flist.f ====
+incdir+logic
logic/periph_pkg.sv
logic/ahb_apb_bridge.sv
logic/gpio_apb.sv
logic/timer_apb.sv
logic/intc_apb.sv
logic/periph_subsys.sv
verif/periph_subsys_tb.sv

// ==== logic/ahb_apb_bridge.sv ====
`include "periph_params.svh"
`default_nettype none

module ahb_apb_bridge import periph_pkg::*; (
   input  wire                     clk,
   input  wire                     rst_i,
   // AHB-lite slave side
   input  wire                     hsel_i,
   input  wire                     htrans_i,          // Single bit, high means NONSEQ
   input  wire                     hwrite_i,
   input  wire  [`BUS_ADDR_W-1:0]  haddr_i,
   input  wire  [`DATA_W-1:0]      hwdata_i,
   output logic [`DATA_W-1:0]      hrdata_o,
   output logic                    hready_o,
   output logic                    hresp_o,
   // APB master side
   output logic [`APB_ADDR_W-1:0]  paddr_o,
   output logic                    pwrite_o,
   output logic [`DATA_W-1:0]      pwdata_o,
   output logic                    penable_o,
   output logic                    gpio_psel_o,
   output logic                    timer_psel_o,
   output logic                    intc_psel_o,
   input  wire  [`DATA_W-1:0]      gpio_prdata_i,
   input  wire  [`DATA_W-1:0]      timer_prdata_i,
   input  wire  [`DATA_W-1:0]      intc_prdata_i
);

   apb_state_t          state;                    // Bridge phase
   periph_sel_t         sel;                      // Target of current transfer
   logic                accept;                   // Transfer taken this edge
   logic [`DATA_W-1:0]  rd_mux;                   // Selected read data

   assign accept = hsel_i & htrans_i & hready_o;  // hready high only in IDLE

   // Address decode into one-hot select
   assign gpio_psel_o  = (state != IDLE) && (sel == SEL_GPIO);
   assign timer_psel_o = (state != IDLE) && (sel == SEL_TIMER);
   assign intc_psel_o  = (state != IDLE) && (sel == SEL_INTC);
   assign penable_o    = (state == ACCESS) && (sel != SEL_NONE);   // Quiet for unmapped

   // Read return mux
   always_comb begin
      case (sel)
         SEL_GPIO:  rd_mux = gpio_prdata_i;
         SEL_TIMER: rd_mux = timer_prdata_i;
         SEL_INTC:  rd_mux = intc_prdata_i;
         default:   rd_mux = '0;                  // Unmapped reads as zero
      endcase
   end

   // Phase sequencing and AHB handshake
   always_ff @(posedge clk) begin
      if (rst_i) begin
         state    <= IDLE;
         sel      <= SEL_NONE;
         pwrite_o <= 1'b0;
         hready_o <= 1'b1;                        // Ready out of reset
         hresp_o  <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               hresp_o <= 1'b0;                   // Error lasts one cycle
               if (accept) begin
                  state    <= SETUP;
                  sel      <= periph_sel_t'(haddr_i[`SEL_LSB+`SEL_W-1:`SEL_LSB]);
                  pwrite_o <= hwrite_i;
                  hready_o <= 1'b0;               // First wait cycle
               end
            end
            SETUP: begin
               state <= ACCESS;                   // Second wait cycle
            end
            ACCESS: begin
               state    <= IDLE;
               hready_o <= 1'b1;                  // Data phase completes
               hresp_o  <= (sel == SEL_NONE);
            end
            default: begin
               state    <= IDLE;
               hready_o <= 1'b1;
            end
         endcase
      end
   end

   // Address, write data and read data capture
   always_ff @(posedge clk) begin
      if (accept) begin
         paddr_o <= haddr_i[`APB_ADDR_W-1:0];     // Local offset only
      end
      if (state == SETUP) begin
         pwdata_o <= hwdata_i;                    // Master holds data through waits
      end
      if (state == ACCESS) begin
         hrdata_o <= rd_mux;                      // Valid with hready high
      end
   end

endmodule

`default_nettype wire

// ==== logic/gpio_apb.sv ====
`include "periph_params.svh"
`default_nettype none

module gpio_apb import periph_pkg::*; (
   input  wire                     clk,
   input  wire                     rst_i,
   input  wire                     psel_i,
   input  wire                     penable_i,
   input  wire                     pwrite_i,
   input  wire  [`APB_ADDR_W-1:0]  paddr_i,
   input  wire  [`DATA_W-1:0]      pwdata_i,
   output logic [`DATA_W-1:0]      prdata_o,
   input  wire  [`GPIO_W-1:0]      gpio_in_i,
   output logic [`GPIO_W-1:0]      gpio_out_o,
   output logic                    gpio_irq_o
);

   gpio_reg_t           reg_idx;                  // Word being accessed
   logic                wr_en;                    // Commit on ACCESS edge
   logic [`GPIO_W-1:0]  sync_q1, sync_q2;         // Two flop synchronizer
   logic [`GPIO_W-1:0]  prev_q;                   // Last synchronized value
   logic [`GPIO_W-1:0]  rise;                     // Per pin rising edge
   logic [`GPIO_W-1:0]  irq_en;
   logic [`GPIO_W-1:0]  irq_stat;
   logic [`GPIO_W-1:0]  stat_clr;                 // Write one to clear mask
   logic [`DATA_W-1:0]  rd_val;

   assign reg_idx  = gpio_reg_t'(paddr_i[`REG_OFF_LSB+`REG_IDX_W-1:`REG_OFF_LSB]);
   assign wr_en    = psel_i & penable_i & pwrite_i;
   assign rise     = sync_q2 & ~prev_q;
   assign stat_clr = (wr_en && reg_idx == GPIO_IRQ_STAT) ? pwdata_i[`GPIO_W-1:0] : '0;

   // Pin synchronizer and edge history
   always_ff @(posedge clk) begin
      sync_q1 <= gpio_in_i;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         gpio_out_o <= '0;
         irq_en     <= '0;
         irq_stat   <= '0;
      end else begin
         if (wr_en && reg_idx == GPIO_OUT)    gpio_out_o <= pwdata_i[`GPIO_W-1:0];
         if (wr_en && reg_idx == GPIO_IRQ_EN) irq_en     <= pwdata_i[`GPIO_W-1:0];
         irq_stat <= (irq_stat & ~stat_clr) | (rise & irq_en);   // New edge wins over clear
      end
   end

   // Register readback, zero extended
   always_comb begin
      rd_val = '0;
      case (reg_idx)
         GPIO_OUT:      rd_val[`GPIO_W-1:0] = gpio_out_o;
         GPIO_IN:       rd_val[`GPIO_W-1:0] = sync_q2;
         GPIO_IRQ_EN:   rd_val[`GPIO_W-1:0] = irq_en;
         GPIO_IRQ_STAT: rd_val[`GPIO_W-1:0] = irq_stat;
         default:       rd_val = '0;
      endcase
   end

   assign prdata_o   = psel_i ? rd_val : '0;
   assign gpio_irq_o = |irq_stat;                 // Any latched edge

endmodule

`default_nettype wire

// ==== logic/intc_apb.sv ====
`include "periph_params.svh"
`default_nettype none

module intc_apb import periph_pkg::*; (
   input  wire                     clk,
   input  wire                     rst_i,
   input  wire                     psel_i,
   input  wire                     penable_i,
   input  wire                     pwrite_i,
   input  wire  [`APB_ADDR_W-1:0]  paddr_i,
   input  wire  [`DATA_W-1:0]      pwdata_i,
   output logic [`DATA_W-1:0]      prdata_o,
   input  wire  [`IRQ_NUM-1:0]     irq_src_i,
   input  wire                     irq_ack_i,     // One cycle CPU acknowledge
   output logic                    cpu_irq_o
);

   intc_reg_t           reg_idx;                  // Word being accessed
   logic                wr_en;
   logic [`IRQ_NUM-1:0] pend_q;                   // Latched sources
   logic [`IRQ_NUM-1:0] en_q;                     // Source mask
   logic [`IRQ_NUM-1:0] act;                      // Enabled and pending
   logic [`IRQ_NUM-1:0] lowest;                   // One hot lowest active
   logic [`IRQ_NUM-1:0] sw_clr;                   // From INTC_CLR write
   logic [`IRQ_NUM-1:0] ack_clr;                  // From CPU acknowledge
   logic [`DATA_W-1:0]  act_id;                   // Index or ID_NONE
   logic [`DATA_W-1:0]  rd_val;

   assign reg_idx = intc_reg_t'(paddr_i[`REG_OFF_LSB+`REG_IDX_W-1:`REG_OFF_LSB]);
   assign wr_en   = psel_i & penable_i & pwrite_i;
   assign act     = pend_q & en_q;
   assign lowest  = act & (~act + 1'b1);          // Isolate lowest set bit
   assign sw_clr  = (wr_en && reg_idx == INTC_CLR) ? pwdata_i[`IRQ_NUM-1:0] : '0;
   assign ack_clr = irq_ack_i ? lowest : '0;

   // Priority encode, index 0 highest
   always_comb begin
      act_id = `ID_NONE;
      for (int i = `IRQ_NUM-1; i >= 0; i--) begin
         if (act[i]) act_id = 32'(i);
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         pend_q <= '0;
         en_q   <= '0;
      end else begin
         if (wr_en && reg_idx == INTC_EN) en_q <= pwdata_i[`IRQ_NUM-1:0];
         pend_q <= (pend_q & ~(sw_clr | ack_clr)) | irq_src_i;   // Live source re-arms
      end
   end

   // Register readback
   always_comb begin
      rd_val = '0;
      case (reg_idx)
         INTC_PEND: rd_val[`IRQ_NUM-1:0] = pend_q;
         INTC_EN:   rd_val[`IRQ_NUM-1:0] = en_q;
         INTC_CLR:  rd_val = '0;                  // Write only
         INTC_ID:   rd_val = act_id;
         default:   rd_val = '0;
      endcase
   end

   assign prdata_o  = psel_i ? rd_val : '0;
   assign cpu_irq_o = |act;                       // Same cycle as pending and mask

endmodule

`default_nettype wire

// ==== logic/periph_params.svh ====
`default_nettype none

`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// Bus widths
`define DATA_W        32             // AHB and APB data
`define BUS_ADDR_W    16             // AHB byte address
`define APB_ADDR_W    12             // Peripheral local window

// Address map
`define SEL_LSB       12             // Peripheral select at haddr[13:12]
`define SEL_W         2              // Select field width
`define REG_OFF_LSB   2              // Word index inside a peripheral
`define REG_IDX_W     2              // Four registers per block

// Peripheral sizing
`define GPIO_W        16             // Pins per direction
`define IRQ_NUM       3              // Interrupt sources
`define IRQ_GPIO      0              // Source index of GPIO edge irq
`define IRQ_TIMER     1              // Source index of timer wrap
`define IRQ_EXT       2              // Source index of external line
`define ID_NONE       32'h8000_0000  // ID read with nothing active

`endif

`default_nettype wire

// ==== logic/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

   // Bridge sequencing
   typedef enum logic [1:0] {
      IDLE   = 2'd0,                  // Waiting for an AHB transfer
      SETUP  = 2'd1,                  // psel up, penable down
      ACCESS = 2'd2                   // psel and penable up
   } apb_state_t;

   // Decoded haddr[13:12]
   typedef enum logic [1:0] {
      SEL_GPIO  = 2'd0,
      SEL_TIMER = 2'd1,
      SEL_INTC  = 2'd2,
      SEL_NONE  = 2'd3                // Unmapped, error response
   } periph_sel_t;

   // GPIO register index
   typedef enum logic [1:0] {
      GPIO_OUT      = 2'd0,           // Output latch
      GPIO_IN       = 2'd1,           // Synchronized pins, read only
      GPIO_IRQ_EN   = 2'd2,           // Rising edge enable mask
      GPIO_IRQ_STAT = 2'd3            // Edge status, write one to clear
   } gpio_reg_t;

   // Timer register index
   typedef enum logic [1:0] {
      TMR_LOAD  = 2'd0,               // Reload value
      TMR_CTRL  = 2'd1,               // Bit 0 run, bit 1 irq enable
      TMR_COUNT = 2'd2,               // Live count, read only
      TMR_STAT  = 2'd3                // Wrap flag, write one to clear
   } timer_reg_t;

   // Interrupt controller register index
   typedef enum logic [1:0] {
      INTC_PEND = 2'd0,               // Latched sources, read only
      INTC_EN   = 2'd1,               // Per source mask
      INTC_CLR  = 2'd2,               // Write one to clear pending
      INTC_ID   = 2'd3                // Lowest active source
   } intc_reg_t;

endpackage

`default_nettype wire

// ==== logic/periph_subsys.sv ====
`include "periph_params.svh"
`default_nettype none

module periph_subsys (
   input  wire                     clk,
   input  wire                     rst_i,
   // AHB-lite port
   input  wire                     hsel_i,
   input  wire                     htrans_i,
   input  wire                     hwrite_i,
   input  wire  [`BUS_ADDR_W-1:0]  haddr_i,
   input  wire  [`DATA_W-1:0]      hwdata_i,
   output wire  [`DATA_W-1:0]      hrdata_o,
   output wire                     hready_o,
   output wire                     hresp_o,
   // Pins and interrupt lines
   input  wire  [`GPIO_W-1:0]      gpio_in_i,
   output wire  [`GPIO_W-1:0]      gpio_out_o,
   input  wire                     irq_ext_i,
   input  wire                     irq_ack_i,
   output wire                     cpu_irq_o
);

   // Shared APB lines
   wire [`APB_ADDR_W-1:0] apb_paddr;
   wire                   apb_pwrite;
   wire [`DATA_W-1:0]     apb_pwdata;
   wire                   apb_penable;
   // Per peripheral select and read data
   wire                   gpio_psel, timer_psel, intc_psel;
   wire [`DATA_W-1:0]     gpio_prdata, timer_prdata, intc_prdata;
   // Interrupt sources
   wire                   gpio_irq, timer_irq;
   wire [`IRQ_NUM-1:0]    irq_src;

   // Source vector by fixed index
   assign irq_src[`IRQ_GPIO]  = gpio_irq;
   assign irq_src[`IRQ_TIMER] = timer_irq;
   assign irq_src[`IRQ_EXT]   = irq_ext_i;

   ahb_apb_bridge u_bridge (
      .clk            (clk),             .rst_i          (rst_i),
      .hsel_i         (hsel_i),          .htrans_i       (htrans_i),
      .hwrite_i       (hwrite_i),        .haddr_i        (haddr_i),
      .hwdata_i       (hwdata_i),        .hrdata_o       (hrdata_o),
      .hready_o       (hready_o),        .hresp_o        (hresp_o),
      .paddr_o        (apb_paddr),       .pwrite_o       (apb_pwrite),
      .pwdata_o       (apb_pwdata),      .penable_o      (apb_penable),
      .gpio_psel_o    (gpio_psel),       .timer_psel_o   (timer_psel),
      .intc_psel_o    (intc_psel),       .gpio_prdata_i  (gpio_prdata),
      .timer_prdata_i (timer_prdata),    .intc_prdata_i  (intc_prdata)
   );

   gpio_apb u_gpio (
      .clk        (clk),          .rst_i      (rst_i),
      .psel_i     (gpio_psel),    .penable_i  (apb_penable),
      .pwrite_i   (apb_pwrite),   .paddr_i    (apb_paddr),
      .pwdata_i   (apb_pwdata),   .prdata_o   (gpio_prdata),
      .gpio_in_i  (gpio_in_i),    .gpio_out_o (gpio_out_o),
      .gpio_irq_o (gpio_irq)
   );

   timer_apb u_timer (
      .clk         (clk),          .rst_i       (rst_i),
      .psel_i      (timer_psel),   .penable_i   (apb_penable),
      .pwrite_i    (apb_pwrite),   .paddr_i     (apb_paddr),
      .pwdata_i    (apb_pwdata),   .prdata_o    (timer_prdata),
      .timer_irq_o (timer_irq)
   );

   intc_apb u_intc (
      .clk       (clk),          .rst_i     (rst_i),
      .psel_i    (intc_psel),    .penable_i (apb_penable),
      .pwrite_i  (apb_pwrite),   .paddr_i   (apb_paddr),
      .pwdata_i  (apb_pwdata),   .prdata_o  (intc_prdata),
      .irq_src_i (irq_src),      .irq_ack_i (irq_ack_i),
      .cpu_irq_o (cpu_irq_o)
   );

endmodule

`default_nettype wire

// ==== logic/timer_apb.sv ====
`include "periph_params.svh"
`default_nettype none

module timer_apb import periph_pkg::*; (
   input  wire                     clk,
   input  wire                     rst_i,
   input  wire                     psel_i,
   input  wire                     penable_i,
   input  wire                     pwrite_i,
   input  wire  [`APB_ADDR_W-1:0]  paddr_i,
   input  wire  [`DATA_W-1:0]      pwdata_i,
   output logic [`DATA_W-1:0]      prdata_o,
   output logic                    timer_irq_o
);

   timer_reg_t          reg_idx;                  // Word being accessed
   logic                wr_en;
   logic [`DATA_W-1:0]  load_q;                   // Reload value
   logic [`DATA_W-1:0]  count_q;                  // Down counter
   logic                run_en;                   // CTRL bit 0
   logic                irq_en;                   // CTRL bit 1
   logic                stat_q;                   // Wrap seen
   logic                wrap;                     // Counter at zero while running
   logic                stat_clr;
   logic [`DATA_W-1:0]  rd_val;

   assign reg_idx  = timer_reg_t'(paddr_i[`REG_OFF_LSB+`REG_IDX_W-1:`REG_OFF_LSB]);
   assign wr_en    = psel_i & penable_i & pwrite_i;
   assign wrap     = run_en && (count_q == '0);
   assign stat_clr = wr_en && (reg_idx == TMR_STAT) && pwdata_i[0];

   // Control and status
   always_ff @(posedge clk) begin
      if (rst_i) begin
         run_en <= 1'b0;
         irq_en <= 1'b0;
         stat_q <= 1'b0;
         load_q <= '0;
      end else begin
         if (wr_en && reg_idx == TMR_LOAD) load_q <= pwdata_i;
         if (wr_en && reg_idx == TMR_CTRL) begin
            run_en <= pwdata_i[0];
            irq_en <= pwdata_i[1];
         end
         if (wrap)          stat_q <= 1'b1;       // Wrap wins over clear
         else if (stat_clr) stat_q <= 1'b0;
      end
   end

   // Counter, period is LOAD+1
   always_ff @(posedge clk) begin
      if (rst_i) begin
         count_q <= '0;
      end else if (wr_en && reg_idx == TMR_LOAD) begin
         count_q <= pwdata_i;                     // LOAD write restarts count
      end else if (wrap) begin
         count_q <= load_q;
      end else if (run_en) begin
         count_q <= count_q - 1'b1;
      end
   end

   // Register readback
   always_comb begin
      rd_val = '0;
      case (reg_idx)
         TMR_LOAD:  rd_val = load_q;
         TMR_CTRL:  rd_val[1:0] = {irq_en, run_en};
         TMR_COUNT: rd_val = count_q;
         TMR_STAT:  rd_val[0] = stat_q;
         default:   rd_val = '0;
      endcase
   end

   assign prdata_o    = psel_i ? rd_val : '0;
   assign timer_irq_o = stat_q & irq_en;          // Level until cleared

endmodule

`default_nettype wire

// ==== verif/periph_subsys_tb.sv ====
`include "periph_params.svh"
`default_nettype none

module periph_subsys_tb import periph_pkg::*; ();

   localparam int N_RAND   = 40;                  // Random write/read pairs
   localparam int N_BAD    = 8;                   // Unmapped slot transfers
   localparam int N_PINS   = 8;                   // GPIO_IN samples
   localparam int N_EDGE   = 3;                   // Edge interrupt rounds
   localparam int N_IRQ    = 4;                   // Interrupt controller rounds
   localparam int MAX_LOAD = 20;
   localparam int N_XFERS  = 12 + 2*N_RAND + 2*N_BAD + 3 + N_PINS + 4*N_EDGE + 9 + 13*N_IRQ;
   localparam int N_WAITS  = 10 + 4*N_PINS + 8*N_EDGE + 2*(MAX_LOAD+10) + 20*N_IRQ;
   localparam int WDOG_T   = (N_XFERS*4 + N_WAITS + 200) * 8;

   logic                    clk, rst_i;
   logic                    hsel_i, htrans_i, hwrite_i;
   logic [`BUS_ADDR_W-1:0]  haddr_i;
   logic [`DATA_W-1:0]      hwdata_i, hrdata_o;
   logic                    hready_o, hresp_o;
   logic [`GPIO_W-1:0]      gpio_in_i, gpio_out_o;
   logic                    irq_ext_i, irq_ack_i, cpu_irq_o;
   integer                  seed;
   int                      errors, checks;
   string                   test_name;

   // Register model for the random bus test
   periph_sel_t         rw_sel   [4] = '{SEL_GPIO, SEL_GPIO, SEL_TIMER, SEL_INTC};
   logic [1:0]          rw_idx   [4] = '{GPIO_OUT, GPIO_IRQ_EN, TMR_LOAD, INTC_EN};
   logic [`DATA_W-1:0]  rw_mask  [4] = '{32'h0000_FFFF, 32'h0000_FFFF, 32'hFFFF_FFFF, 32'h7};
   string               rw_name  [4] = '{"GPIO_OUT", "GPIO_IRQ_EN", "TMR_LOAD", "INTC_EN"};
   logic [`DATA_W-1:0]  rw_model [4] = '{default: '0};   // Last value written after masking

   periph_subsys dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      #(WDOG_T);
      $display("Watchdog expired after %0d time units, the run timed out", WDOG_T);
      $display("Simulation finished: FAIL");
      $finish;
   end

   task automatic check_data(input string what, input logic [`DATA_W-1:0] exp,
                             input logic [`DATA_W-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
      end
   endtask

   task automatic check_resp(input string what, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s %s: expected hresp %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic check_state(input string what, input periph_sel_t exp, input periph_sel_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s %s: expected %s, actual %s", test_name, what, exp.name(),
                  act.name());
      end
   endtask

   task automatic check_level(input string what, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic check_cycles(input string what, input int exp, input int act);
      checks++;
      if (act != exp) begin
         errors++;
         $display("mismatch %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      end
   endtask

   function automatic logic [`BUS_ADDR_W-1:0] addr_of(input periph_sel_t sel,
                                                      input logic [1:0] idx);
      logic [`BUS_ADDR_W-1:0] a;
      a = '0;
      a[`SEL_LSB +: `SEL_W]         = sel;
      a[`REG_OFF_LSB +: `REG_IDX_W] = idx;
      return a;
   endfunction

   function automatic periph_sel_t decode_sel(input logic [`BUS_ADDR_W-1:0] a);
      return periph_sel_t'(a[`SEL_LSB +: `SEL_W]);
   endfunction

   // Which psel is up during the first wait cycle
   function automatic periph_sel_t observed_sel();
      if (dut0.gpio_psel) return SEL_GPIO;
      if (dut0.timer_psel) return SEL_TIMER;
      if (dut0.intc_psel) return SEL_INTC;
      return SEL_NONE;
   endfunction

   function automatic logic [`DATA_W-1:0] expected_id(input logic [`IRQ_NUM-1:0] act);
      for (int i = 0; i < `IRQ_NUM; i++) begin
         if (act[i]) return i;                    // Index 0 wins
      end
      return `ID_NONE;
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   // One AHB transfer entered and left on a falling edge with hready high
   task automatic bus_xfer(input logic wr, input logic [`BUS_ADDR_W-1:0] addr,
                           input logic [`DATA_W-1:0] wdata, output logic [`DATA_W-1:0] rdata);
      int          waits;
      periph_sel_t seen;
      waits    = 0;
      seen     = SEL_NONE;
      hsel_i   = 1'b1;
      htrans_i = 1'b1;
      hwrite_i = wr;
      haddr_i  = addr;
      hwdata_i = wdata;                           // Held until the next transfer
      @(negedge clk);                             // Accept edge passed
      hsel_i   = 1'b0;
      htrans_i = 1'b0;
      while (hready_o !== 1'b1) begin
         waits++;
         if (waits == 1) seen = observed_sel();
         @(negedge clk);
      end
      rdata = hrdata_o;
      check_cycles("hready low cycles", 2, waits);
      check_state("select", decode_sel(addr), seen);
      check_resp("hresp", decode_sel(addr) == SEL_NONE, hresp_o);
   endtask

   task automatic bus_write(input logic [`BUS_ADDR_W-1:0] addr, input logic [`DATA_W-1:0] d);
      logic [`DATA_W-1:0] unused;
      bus_xfer(1'b1, addr, d, unused);
   endtask

   task automatic bus_read(input logic [`BUS_ADDR_W-1:0] addr, output logic [`DATA_W-1:0] d);
      bus_xfer(1'b0, addr, '0, d);
   endtask

   task automatic read_check(input string what, input logic [`BUS_ADDR_W-1:0] addr,
                             input logic [`DATA_W-1:0] exp);
      logic [`DATA_W-1:0] d;
      bus_read(addr, d);
      check_data(what, exp, d);
   endtask

   task automatic test_reset();
      test_name = "reset";
      check_level("hready_o", 1'b1, hready_o);
      check_resp("hresp_o", 1'b0, hresp_o);
      check_level("cpu_irq_o", 1'b0, cpu_irq_o);
      check_data("gpio_out_o", '0, 32'(gpio_out_o));
      for (int s = 0; s < 3; s++) begin
         for (int r = 0; r < 4; r++) begin
            read_check($sformatf("sel %0d reg %0d", s, r), addr_of(periph_sel_t'(s), r),
                       (s == SEL_INTC && r == INTC_ID) ? `ID_NONE : '0);
         end
      end
   endtask

   task automatic test_bus();
      logic [`DATA_W-1:0]     d, hi;
      logic [`BUS_ADDR_W-1:0] a;
      int                     k;
      test_name = "bus";
      for (int i = 0; i < N_RAND; i++) begin
         k  = $unsigned($random(seed)) % 4;
         d  = $random(seed);
         hi = $random(seed);
         a  = addr_of(rw_sel[k], rw_idx[k]);
         a[`BUS_ADDR_W-1:`SEL_LSB+`SEL_W] = hi[1:0];   // Undecoded upper bits
         rw_model[k] = d & rw_mask[k];
         bus_write(a, d);
         read_check(rw_name[k], a, rw_model[k]);
         check_data("gpio_out_o", rw_model[0], 32'(gpio_out_o));
      end
      for (int i = 0; i < N_BAD; i++) begin
         a = $random(seed);
         a[`SEL_LSB +: `SEL_W] = SEL_NONE;
         bus_write(a, $random(seed));             // Must be dropped
         read_check("unmapped read", a, '0);
      end
      check_data("gpio_out_o after unmapped", rw_model[0], 32'(gpio_out_o));
   endtask

   task automatic test_gpio();
      logic [`GPIO_W-1:0] pins, mask;
      test_name = "gpio";
      bus_write(addr_of(SEL_GPIO, GPIO_IRQ_EN), '0);
      for (int i = 0; i < N_PINS; i++) begin
         pins      = $random(seed);
         gpio_in_i = pins;
         wait_cycles(4);                          // Through the synchronizer
         read_check("GPIO_IN", addr_of(SEL_GPIO, GPIO_IN), 32'(pins));
      end
      for (int i = 0; i < N_EDGE; i++) begin
         gpio_in_i = '0;
         wait_cycles(4);
         mask = $random(seed);
         pins = $random(seed);
         bus_write(addr_of(SEL_GPIO, GPIO_IRQ_EN), 32'(mask));
         gpio_in_i = pins;                        // Rising edges on set bits
         wait_cycles(4);
         read_check("GPIO_IRQ_STAT", addr_of(SEL_GPIO, GPIO_IRQ_STAT), 32'(pins & mask));
         bus_write(addr_of(SEL_GPIO, GPIO_IRQ_STAT), 32'h0000_FFFF);
         read_check("GPIO_IRQ_STAT cleared", addr_of(SEL_GPIO, GPIO_IRQ_STAT), '0);
      end
      gpio_in_i = '0;
      wait_cycles(4);
      bus_write(addr_of(SEL_GPIO, GPIO_IRQ_EN), '0);
      bus_write(addr_of(SEL_INTC, INTC_CLR), 32'h7);   // Drop pending left by edges
   endtask

   task automatic test_timer();
      logic [`DATA_W-1:0] load, cnt;
      test_name = "timer";
      load = 3 + $unsigned($random(seed)) % (MAX_LOAD - 2);
      bus_write(addr_of(SEL_TIMER, TMR_LOAD), load);
      bus_write(addr_of(SEL_TIMER, TMR_CTRL), 32'h3);  // Run and irq enable
      repeat (2) begin
         bus_read(addr_of(SEL_TIMER, TMR_COUNT), cnt);
         checks++;
         if (cnt > load) begin
            errors++;
            $display("mismatch %s TMR_COUNT: expected at most 0x%0h, actual 0x%0h",
                     test_name, load, cnt);
         end
      end
      wait_cycles(load + 10);
      read_check("TMR_STAT after wrap", addr_of(SEL_TIMER, TMR_STAT), 32'h1);
      bus_write(addr_of(SEL_TIMER, TMR_CTRL), '0);     // Stop before clearing
      bus_write(addr_of(SEL_TIMER, TMR_STAT), 32'h1);
      wait_cycles(load + 10);
      read_check("TMR_STAT while stopped", addr_of(SEL_TIMER, TMR_STAT), '0);
      bus_write(addr_of(SEL_INTC, INTC_CLR), 32'h7);
   endtask

   task automatic test_intc();
      logic [`IRQ_NUM-1:0] en, fire, pend, act;
      int                  k;
      test_name = "intc";
      pend      = '0;
      for (int i = 0; i < N_IRQ; i++) begin
         en   = $random(seed);
         fire = $random(seed);                    // Sources raised this round
         bus_write(addr_of(SEL_INTC, INTC_EN), 32'(en));
         if (fire[`IRQ_EXT]) begin
            irq_ext_i = 1'b1;
            wait_cycles(1);
            irq_ext_i = 1'b0;
         end
         if (fire[`IRQ_GPIO]) begin
            bus_write(addr_of(SEL_GPIO, GPIO_IRQ_EN), 32'h1);
            gpio_in_i = 16'h1;
            wait_cycles(4);
            bus_write(addr_of(SEL_GPIO, GPIO_IRQ_STAT), 32'h1);
            gpio_in_i = '0;
            wait_cycles(4);
         end
         if (fire[`IRQ_TIMER]) begin
            bus_write(addr_of(SEL_TIMER, TMR_LOAD), 32'h3);
            bus_write(addr_of(SEL_TIMER, TMR_CTRL), 32'h3);
            wait_cycles(8);                       // At least one wrap
            bus_write(addr_of(SEL_TIMER, TMR_CTRL), '0);
            bus_write(addr_of(SEL_TIMER, TMR_STAT), 32'h1);
         end
         pend = pend | fire;                      // All sources low again
         act  = pend & en;
         read_check("INTC_PEND", addr_of(SEL_INTC, INTC_PEND), 32'(pend));
         check_level("cpu_irq_o", |act, cpu_irq_o);
         read_check("INTC_ID", addr_of(SEL_INTC, INTC_ID), expected_id(act));
         while (act != '0) begin
            irq_ack_i = 1'b1;
            wait_cycles(1);
            irq_ack_i = 1'b0;
            k       = expected_id(act);
            pend[k] = 1'b0;                       // Acked source is low
            act     = pend & en;
            check_level("cpu_irq_o after ack", |act, cpu_irq_o);
            read_check("INTC_ID after ack", addr_of(SEL_INTC, INTC_ID), expected_id(act));
         end
         bus_write(addr_of(SEL_INTC, INTC_CLR), 32'h7);   // Masked leftovers
         pend = '0;
      end
   endtask

   initial begin
      seed      = 32'h74a7;
      errors    = 0;
      checks    = 0;
      rst_i     = 1'b1;
      hsel_i    = 1'b0;
      htrans_i  = 1'b0;
      hwrite_i  = 1'b0;
      haddr_i   = '0;
      hwdata_i  = '0;
      gpio_in_i = '0;
      irq_ext_i = 1'b0;
      irq_ack_i = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_i = 1'b0;
      test_reset();
      test_bus();
      test_gpio();
      test_timer();
      test_intc();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
